//--- source/ex_pkg.sv
`default_nettype none

package ex_pkg;

  ////////////////////////////////////////
  // Widths and counts
  ////////////////////////////////////////

  localparam int unsigned xlen      = 32;
  localparam int unsigned rf_addr_w = 6;
  localparam int unsigned n_wspr    = 4;  // Weight SPRs
  localparam int unsigned n_aspr    = 2;  // Activation SPRs

  localparam int unsigned wspr_idx_w   = $clog2(n_wspr);
  localparam int unsigned aspr_idx_w   = $clog2(n_aspr);
  localparam int unsigned n_byte_lanes = xlen / 8;
  localparam int unsigned n_half_lanes = xlen / 16;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [rf_addr_w-1:0]  rf_addr_t;
  typedef logic [wspr_idx_w-1:0] wspr_idx_t;
  typedef logic [aspr_idx_w-1:0] aspr_idx_t;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra,
    alu_slt, alu_sltu,
    alu_eq, alu_ne, alu_lt, alu_ge  // Branch compares
  } alu_op_e;

  typedef enum logic [1:0] {
    mult_mul,    // Low word of a * b
    mult_dot8,   // c + sum of signed byte products
    mult_dot16   // c + sum of signed halfword products
  } mult_op_e;

  ////////////////////////////////////////
  // Port structs
  ////////////////////////////////////////

  typedef struct packed {
    logic    en;
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   c;  // Jump target
  } alu_req_t;

  typedef struct packed {
    logic      en;
    mult_op_e  op;
    word_t     a;
    word_t     b;
    word_t     c;
    logic      spr_sel;  // Dot operands from SPRs
    aspr_idx_t aspr_idx;
    wspr_idx_t wspr_idx;
  } mult_req_t;

  // Activation bank only looks at the low index bit
  typedef struct packed {
    logic      to_wspr;
    logic      to_aspr;
    wspr_idx_t idx;
  } spr_load_t;

  typedef struct packed {
    logic      alu_we;
    rf_addr_t  alu_waddr;
    logic      lsu_we;
    rf_addr_t  lsu_waddr;
    spr_load_t spr_load;
  } wb_ctrl_t;

  typedef struct packed {
    logic     we;
    rf_addr_t waddr;
    word_t    wdata;
  } rf_write_t;

  typedef struct packed {
    logic      wspr_we;
    logic      aspr_we;
    wspr_idx_t idx;
    word_t     wdata;
  } spr_write_t;

endpackage

`default_nettype wire

//--- source/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
  input  alu_req_t alu_req_i,
  output word_t    result_o,
  output logic     cmp_o
);

  word_t                    op_a;
  word_t                    op_b;
  logic [$clog2(xlen)-1:0]  shamt;
  logic                     lt_s;
  logic                     lt_u;
  logic                     is_cmp;

  assign op_a  = alu_req_i.a;
  assign op_b  = alu_req_i.b;
  assign shamt = op_b[$clog2(xlen)-1:0];  // Low bits of b only

  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////

  always_comb begin
    is_cmp = 1'b1;
    cmp_o  = 1'b0;
    case (alu_req_i.op)
      alu_slt:  cmp_o = lt_s;
      alu_sltu: cmp_o = lt_u;
      alu_eq:   cmp_o = (op_a == op_b);
      alu_ne:   cmp_o = (op_a != op_b);
      alu_lt:   cmp_o = lt_s;
      alu_ge:   cmp_o = ~lt_s;
      default:  is_cmp = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  always_comb begin
    result_o = '0;
    if (is_cmp) begin
      result_o = word_t'(cmp_o);  // Zero-extended compare bit
    end else begin
      case (alu_req_i.op)
        alu_add: result_o = op_a + op_b;
        alu_sub: result_o = op_a - op_b;
        alu_and: result_o = op_a & op_b;
        alu_or:  result_o = op_a | op_b;
        alu_xor: result_o = op_a ^ op_b;
        alu_sll: result_o = op_a << shamt;
        alu_srl: result_o = op_a >> shamt;
        // Sign comes from operand a
        alu_sra: result_o = $signed(op_a) >>> shamt;
        default: result_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/ex_spr_bank.sv
`timescale 1ns/1ps
`default_nettype none

module ex_spr_bank import ex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  spr_write_t spr_wr_i,
  input  aspr_idx_t  aspr_idx_i,
  input  wspr_idx_t  wspr_idx_i,
  output word_t      aspr_o,
  output word_t      wspr_o
);

  word_t [n_wspr-1:0] wspr_q;  // Weight words
  word_t [n_aspr-1:0] aspr_q;  // Activation words
  aspr_idx_t          aspr_widx;

  // Activation bank is addressed by the low index bits
  assign aspr_widx = spr_wr_i.idx[aspr_idx_w-1:0];

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wspr_q <= '0;
      aspr_q <= '0;
    end else begin
      if (spr_wr_i.wspr_we) begin
        wspr_q[spr_wr_i.idx] <= spr_wr_i.wdata;
      end
      if (spr_wr_i.aspr_we) begin
        aspr_q[aspr_widx] <= spr_wr_i.wdata;
      end
    end
  end

  // Read ports show current contents
  assign wspr_o = wspr_q[wspr_idx_i];
  assign aspr_o = aspr_q[aspr_idx_i];

endmodule

`default_nettype wire

//--- source/ex_dotp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_dotp_unit import ex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  mult_req_t  mult_req_i,
  input  spr_write_t spr_wr_i,
  output word_t      result_o
);

  word_t aspr_rdata;
  word_t wspr_rdata;
  word_t dot_a;
  word_t dot_b;

  logic signed [15:0]     prod8  [n_byte_lanes];
  logic signed [31:0]     prod16 [n_half_lanes];
  logic signed [xlen-1:0] sum8;
  logic signed [xlen-1:0] sum16;

  ex_spr_bank u_spr_bank (
    .clk        (clk),
    .rst_n      (rst_n),
    .spr_wr_i   (spr_wr_i),
    .aspr_idx_i (mult_req_i.aspr_idx),
    .wspr_idx_i (mult_req_i.wspr_idx),
    .aspr_o     (aspr_rdata),
    .wspr_o     (wspr_rdata)
  );

  ////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////

  // Activation feeds side a, weight feeds side b
  assign dot_a = mult_req_i.spr_sel ? aspr_rdata : mult_req_i.a;
  assign dot_b = mult_req_i.spr_sel ? wspr_rdata : mult_req_i.b;

  ////////////////////////////////////////
  // Lane arithmetic
  ////////////////////////////////////////

  always_comb begin
    sum8 = $signed(mult_req_i.c);
    for (int i = 0; i < n_byte_lanes; i++) begin
      prod8[i] = $signed(dot_a[8*i +: 8]) * $signed(dot_b[8*i +: 8]);
      sum8     = sum8 + prod8[i];  // Wraps at xlen
    end
  end

  always_comb begin
    sum16 = $signed(mult_req_i.c);
    for (int i = 0; i < n_half_lanes; i++) begin
      prod16[i] = $signed(dot_a[16*i +: 16]) * $signed(dot_b[16*i +: 16]);
      sum16     = sum16 + prod16[i];
    end
  end

  always_comb begin
    case (mult_req_i.op)
      mult_mul:   result_o = mult_req_i.a * mult_req_i.b;  // Low word kept
      mult_dot8:  result_o = word_t'(sum8);
      mult_dot16: result_o = word_t'(sum16);
      default:    result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/ex_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module ex_writeback import ex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       alu_en_i,
  input  word_t      alu_result_i,
  input  mult_req_t  mult_req_i,
  input  word_t      mult_result_i,
  input  logic       csr_access_i,
  input  word_t      csr_rdata_i,
  input  wb_ctrl_t   wb_ctrl_i,
  input  logic       lsu_en_i,
  input  logic       lsu_ready_i,
  input  logic       lsu_err_i,
  input  word_t      lsu_rdata_i,
  input  logic       wb_ready_i,
  input  logic       branch_in_ex_i,
  output rf_write_t  fw_o,
  output rf_write_t  wb_o,
  output spr_write_t spr_wr_o,
  output logic       compute_load_o,
  output logic       ex_ready_o,
  output logic       ex_valid_o
);

  logic      lsu_wr_en;
  logic      lsu_we_q;
  rf_addr_t  lsu_waddr_q;
  spr_load_t spr_load_q;
  logic      spr_sel_q;
  word_t     dot_q;

  // Load and dot product issued together
  assign compute_load_o = mult_req_i.en & mult_req_i.spr_sel;

  ////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////

  // Branches retire in EX, so ready may rise without WB
  assign ex_ready_o = (lsu_ready_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_req_i.en | csr_access_i | lsu_en_i)
                      & lsu_ready_i & wb_ready_i;

  ////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////

  always_comb begin
    fw_o.we    = wb_ctrl_i.alu_we;
    fw_o.waddr = wb_ctrl_i.alu_waddr;
    if (compute_load_o) begin
      fw_o.wdata = alu_result_i;  // Dot result goes out on the LSU port
    end else if (csr_access_i) begin
      fw_o.wdata = csr_rdata_i;
    end else if (mult_req_i.en) begin
      fw_o.wdata = mult_result_i;
    end else if (alu_en_i) begin
      fw_o.wdata = alu_result_i;
    end else begin
      fw_o.wdata = '0;
    end
  end

  ////////////////////////////////////////
  // EX/WB pipeline register
  ////////////////////////////////////////

  assign lsu_wr_en = wb_ctrl_i.lsu_we & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
      spr_load_q  <= '0;
      spr_sel_q   <= 1'b0;
    end else if (ex_valid_o) begin
      lsu_we_q   <= lsu_wr_en;
      spr_load_q <= wb_ctrl_i.spr_load;
      spr_sel_q  <= mult_req_i.spr_sel;
      if (lsu_wr_en) begin
        lsu_waddr_q <= wb_ctrl_i.lsu_waddr;
      end
    end else if (wb_ready_i) begin
      lsu_we_q <= 1'b0;  // Bubble with nothing to write
    end
  end

  // Dot result one cycle behind the multiplier
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dot_q <= '0;
    end else begin
      dot_q <= mult_result_i;
    end
  end

  ////////////////////////////////////////
  // LSU port and SPR write
  ////////////////////////////////////////

  assign wb_o.we    = lsu_we_q;
  assign wb_o.waddr = lsu_waddr_q;
  assign wb_o.wdata = spr_sel_q ? dot_q : lsu_rdata_i;

  // Load data lands in the SPR even when the GPR takes the dot result
  assign spr_wr_o.wspr_we = lsu_we_q & spr_load_q.to_wspr;
  assign spr_wr_o.aspr_we = lsu_we_q & spr_load_q.to_aspr;
  assign spr_wr_o.idx     = spr_load_q.idx;
  assign spr_wr_o.wdata   = lsu_rdata_i;

endmodule

`default_nettype wire

//--- source/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // Requests from decode
  input  alu_req_t  alu_req_i,
  input  mult_req_t mult_req_i,
  input  wb_ctrl_t  wb_ctrl_i,

  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,

  // Load/store unit
  input  logic      lsu_en_i,
  input  logic      lsu_ready_i,
  input  logic      lsu_err_i,
  input  word_t     lsu_rdata_i,

  input  logic      branch_in_ex_i,
  input  logic      wb_ready_i,

  output rf_write_t fw_o,               // To register file and decode
  output rf_write_t wb_o,               // LSU write port
  output logic      branch_decision_o,
  output word_t     jump_target_o,
  output logic      compute_load_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  word_t      alu_result;
  word_t      mult_result;
  spr_write_t spr_wr;

  assign jump_target_o = alu_req_i.c;

  ex_alu u_alu (
    .alu_req_i (alu_req_i),
    .result_o  (alu_result),
    .cmp_o     (branch_decision_o)
  );

  ex_dotp_unit u_dotp (
    .clk        (clk),
    .rst_n      (rst_n),
    .mult_req_i (mult_req_i),
    .spr_wr_i   (spr_wr),
    .result_o   (mult_result)
  );

  ex_writeback u_writeback (
    .clk            (clk),
    .rst_n          (rst_n),
    .alu_en_i       (alu_req_i.en),
    .alu_result_i   (alu_result),
    .mult_req_i     (mult_req_i),
    .mult_result_i  (mult_result),
    .csr_access_i   (csr_access_i),
    .csr_rdata_i    (csr_rdata_i),
    .wb_ctrl_i      (wb_ctrl_i),
    .lsu_en_i       (lsu_en_i),
    .lsu_ready_i    (lsu_ready_i),
    .lsu_err_i      (lsu_err_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .wb_ready_i     (wb_ready_i),
    .branch_in_ex_i (branch_in_ex_i),
    .fw_o           (fw_o),
    .wb_o           (wb_o),
    .spr_wr_o       (spr_wr),
    .compute_load_o (compute_load_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

endmodule

`default_nettype wire

//--- dv/ex_stage_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_properties import ex_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input mult_req_t mult_req_i,
  input logic      lsu_ready_i,
  input logic      wb_ready_i,
  input rf_write_t wb_o,
  input logic      compute_load_o,
  input logic      ex_valid_o
);

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  valid_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |-> (wb_ready_i && lsu_ready_i))
    else $error("ex_valid_o high while LSU or WB side is not ready");

  // Load-compute pair flag
  compute_load_flag: assert property (@(posedge clk) disable iff (!rst_n)
    compute_load_o == (mult_req_i.en && mult_req_i.spr_sel))
    else $error("compute_load_o differs from mult enable and spr_sel");

  ////////////////////////////////////////
  // Reset
  ////////////////////////////////////////

  wb_quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !wb_o.we)
    else $error("wb_o.we high in the first cycle after reset");

endmodule

bind ex_stage ex_stage_properties u_properties (
  .clk            (clk),
  .rst_n          (rst_n),
  .mult_req_i     (mult_req_i),
  .lsu_ready_i    (lsu_ready_i),
  .wb_ready_i     (wb_ready_i),
  .wb_o           (wb_o),
  .compute_load_o (compute_load_o),
  .ex_valid_o     (ex_valid_o)
);

`default_nettype wire

//--- dv/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb import ex_pkg::*; ();

  typedef struct packed {
    alu_req_t  alu;
    mult_req_t mult;
    wb_ctrl_t  ctrl;
    logic      csr;
    word_t     csr_data;
    logic      lsu_en;
    logic      lsu_ready;
    logic      lsu_err;
    word_t     lsu_data;
    logic      branch;
    logic      wb_ready;
    rf_write_t fw_exp;    // Expected values from here on
    rf_write_t wb_exp;
    logic      valid_exp;
    logic      ready_exp;
    logic      cload_exp;
    logic      bdec_exp;
    word_t     jt_exp;
  } entry_t;

  logic      clk = 1'b0;
  logic      rst_n;
  alu_req_t  alu_req_i;
  mult_req_t mult_req_i;
  wb_ctrl_t  wb_ctrl_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      lsu_en_i, lsu_ready_i, lsu_err_i;
  word_t     lsu_rdata_i;
  logic      branch_in_ex_i, wb_ready_i;
  rf_write_t fw_o, wb_o;
  logic      branch_decision_o, compute_load_o, ex_ready_o, ex_valid_o;
  word_t     jump_target_o;

  entry_t    table_q[$];
  logic      mdl_we;       // Model of the EX/WB register
  rf_addr_t  mdl_waddr;
  spr_load_t mdl_load;
  logic      mdl_sel;
  word_t     mdl_dot;
  word_t     mdl_wspr [n_wspr];
  word_t     mdl_aspr [n_aspr];

  ex_stage dut (.*);

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic branch_taken(alu_req_t r);
    case (r.op)
      alu_slt, alu_lt: return $signed(r.a) < $signed(r.b);
      alu_sltu:        return r.a < r.b;
      alu_eq:          return r.a == r.b;
      alu_ne:          return r.a != r.b;
      alu_ge:          return $signed(r.a) >= $signed(r.b);
      default:         return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_expected(alu_req_t r);
    logic [4:0] sh;
    word_t      fill;
    sh   = r.b[4:0];
    fill = r.a[xlen-1] ? ~(32'hffff_ffff >> sh) : '0;  // Sign bits for sra
    case (r.op)
      alu_add: return r.a + r.b;
      alu_sub: return r.a - r.b;
      alu_and: return r.a & r.b;
      alu_or:  return r.a | r.b;
      alu_xor: return r.a ^ r.b;
      alu_sll: return r.a << sh;
      alu_srl: return r.a >> sh;
      alu_sra: return (r.a >> sh) | fill;
      default: return word_t'(branch_taken(r));
    endcase
  endfunction

  function automatic word_t lane_dot(word_t a, word_t b, word_t c, logic halves);
    int acc;
    acc = int'(c);
    for (int i = 0; i < 4; i++) begin
      if (!halves) acc += int'($signed(a[8*i +: 8])) * int'($signed(b[8*i +: 8]));
      else if (i < 2) acc += int'($signed(a[16*i +: 16])) * int'($signed(b[16*i +: 16]));
    end
    return word_t'(acc);
  endfunction

  // Fills the expected fields, then advances the model past the clock edge
  task automatic model_step(inout entry_t e);
    word_t ma, mb, mres, ares;
    logic  wr;
    ma   = e.mult.spr_sel ? mdl_aspr[e.mult.aspr_idx] : e.mult.a;
    mb   = e.mult.spr_sel ? mdl_wspr[e.mult.wspr_idx] : e.mult.b;
    mres = (e.mult.op == mult_mul) ? e.mult.a * e.mult.b
         : lane_dot(ma, mb, e.mult.c, e.mult.op == mult_dot16);
    ares = alu_expected(e.alu);
    e.valid_exp = (e.alu.en | e.mult.en | e.csr | e.lsu_en) & e.lsu_ready & e.wb_ready;
    e.ready_exp = (e.lsu_ready & e.wb_ready) | e.branch;
    e.cload_exp = e.mult.en & e.mult.spr_sel;
    e.bdec_exp  = branch_taken(e.alu);
    e.jt_exp    = e.alu.c;
    e.fw_exp.we    = e.ctrl.alu_we;
    e.fw_exp.waddr = e.ctrl.alu_waddr;
    if (e.cload_exp) e.fw_exp.wdata = ares;
    else if (e.csr) e.fw_exp.wdata = e.csr_data;
    else if (e.mult.en) e.fw_exp.wdata = mres;
    else e.fw_exp.wdata = e.alu.en ? ares : '0;
    e.wb_exp.we    = mdl_we;
    e.wb_exp.waddr = mdl_waddr;
    e.wb_exp.wdata = mdl_sel ? mdl_dot : e.lsu_data;
    // Clock edge
    if (mdl_we && mdl_load.to_wspr) mdl_wspr[mdl_load.idx] = e.lsu_data;
    if (mdl_we && mdl_load.to_aspr) mdl_aspr[mdl_load.idx[0]] = e.lsu_data;
    mdl_dot = mres;
    wr = e.ctrl.lsu_we & ~e.lsu_err;
    if (e.valid_exp) begin
      mdl_we   = wr;
      mdl_load = e.ctrl.spr_load;
      mdl_sel  = e.mult.spr_sel;
      if (wr) mdl_waddr = e.ctrl.lsu_waddr;
    end else if (e.wb_ready) begin
      mdl_we = 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  function automatic entry_t blank_entry();
    entry_t e;
    e           = '0;
    e.lsu_ready = 1'b1;
    e.wb_ready  = 1'b1;
    e.lsu_data  = $urandom;
    return e;
  endfunction

  function automatic entry_t load_entry(logic err, spr_load_t tag);
    entry_t e;
    e                = blank_entry();
    e.lsu_en         = 1'b1;
    e.lsu_err        = err;
    e.ctrl.lsu_we    = 1'b1;
    e.ctrl.lsu_waddr = rf_addr_t'($urandom);
    e.ctrl.spr_load  = tag;
    return e;
  endfunction

  task automatic add_entry(entry_t e);
    model_step(e);
    table_q.push_back(e);
  endtask

  task automatic build_table();
    entry_t    e;
    wspr_idx_t k;
    aspr_idx_t j;
    mdl_we = 1'b0;
    mdl_waddr = '0;
    mdl_load = '0;
    mdl_sel = 1'b0;
    mdl_dot = '0;
    foreach (mdl_wspr[i]) mdl_wspr[i] = '0;
    foreach (mdl_aspr[i]) mdl_aspr[i] = '0;
    k = wspr_idx_t'($urandom);
    j = aspr_idx_t'($urandom);
    for (int op = 0; op <= int'(alu_ge); op++) begin
      e = blank_entry();
      e.alu = '{en: 1'b1, op: alu_op_e'(op), a: $urandom, b: $urandom, c: $urandom};
      if (op == int'(alu_eq)) e.alu.b = e.alu.a;  // Hit the equal case
      e.ctrl.alu_we    = 1'b1;
      e.ctrl.alu_waddr = rf_addr_t'($urandom);
      add_entry(e);
    end
    for (int op = 0; op <= int'(mult_dot16); op++) begin
      e = blank_entry();
      e.mult = '{en: 1'b1, op: mult_op_e'(op), a: $urandom, b: $urandom, c: $urandom,
                 default: '0};
      e.ctrl.alu_we = 1'b1;
      add_entry(e);
    end
    e.alu   = '{en: 1'b1, op: alu_add, a: $urandom, b: $urandom, c: $urandom};
    e.csr   = 1'b1;  // Priority csr, then mult, then ALU
    e.csr_data = $urandom;
    add_entry(e);
    e.csr = 1'b0;
    add_entry(e);
    e.mult.en = 1'b0;
    add_entry(e);
    e.alu.en = 1'b0;
    e.csr    = 1'b1;  // CSR read on its own
    add_entry(e);
    add_entry(load_entry(1'b0, '0));
    add_entry(blank_entry());
    add_entry(load_entry(1'b1, '0));
    add_entry(blank_entry());
    // SPR loads, then a dot product on them
    add_entry(load_entry(1'b0, '{to_wspr: 1'b1, to_aspr: 1'b0, idx: k}));
    add_entry(load_entry(1'b0, '{to_wspr: 1'b0, to_aspr: 1'b1, idx: wspr_idx_t'(j)}));
    add_entry(blank_entry());
    e = load_entry(1'b0, '0);
    e.alu  = '{en: 1'b1, op: alu_xor, a: $urandom, b: $urandom, c: $urandom};
    e.mult = '{en: 1'b1, op: mult_dot8, c: $urandom, spr_sel: 1'b1, aspr_idx: j,
               wspr_idx: k, default: '0};
    e.ctrl.alu_we = 1'b1;
    add_entry(e);
    add_entry(blank_entry());
    // Back-pressure with a load in WB
    add_entry(load_entry(1'b0, '0));
    e = blank_entry();
    e.alu.en   = 1'b1;
    e.wb_ready = 1'b0;
    add_entry(e);
    e.branch = 1'b1;
    add_entry(e);
    e.branch    = 1'b0;
    e.wb_ready  = 1'b1;
    e.lsu_ready = 1'b0;  // LSU stall alone
    add_entry(e);
    add_entry(blank_entry());
  endtask

  ////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "Value check on %s failed", name);
    end
  endtask

  task automatic wait_for_valid();
    int tries;
    tries = 0;
    while (!ex_valid_o && tries < 3) begin
      #1;
      tries++;
    end
    if (!ex_valid_o) begin
      $display("ex_valid_o did not rise for a valid entry at %0t ns", $time);
      $display("Done: errors found");
      $fatal(1, "Timed out waiting for ex_valid_o");
    end
  endtask

  task automatic apply_entry(entry_t e);
    alu_req_i      = e.alu;
    mult_req_i     = e.mult;
    wb_ctrl_i      = e.ctrl;
    csr_access_i   = e.csr;
    csr_rdata_i    = e.csr_data;
    lsu_en_i       = e.lsu_en;
    lsu_ready_i    = e.lsu_ready;
    lsu_err_i      = e.lsu_err;
    lsu_rdata_i    = e.lsu_data;
    branch_in_ex_i = e.branch;
    wb_ready_i     = e.wb_ready;
  endtask

  initial begin
    void'($urandom(32'h76639d60));
    rst_n = 1'b0;
    apply_entry('0);
    build_table();
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    foreach (table_q[i]) begin
      @(posedge clk);
      #1 apply_entry(table_q[i]);
      if (table_q[i].valid_exp) wait_for_valid();
      @(negedge clk);  // Outputs settled well before the next edge
      check_value("fw_o", 64'(fw_o), 64'(table_q[i].fw_exp));
      check_value("wb_o", 64'(wb_o), 64'(table_q[i].wb_exp));
      check_value("ex_valid_o", 64'(ex_valid_o), 64'(table_q[i].valid_exp));
      check_value("ex_ready_o", 64'(ex_ready_o), 64'(table_q[i].ready_exp));
      check_value("compute_load_o", 64'(compute_load_o), 64'(table_q[i].cload_exp));
      check_value("branch_decision_o", 64'(branch_decision_o), 64'(table_q[i].bdec_exp));
      check_value("jump_target_o", 64'(jump_target_o), 64'(table_q[i].jt_exp));
    end
    $display("Done: no errors");
    $finish;
  end

  // Watchdog
  initial begin
    #50us;
    $display("Simulation ran past its time limit");
    $display("Done: errors found");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

//--- ex_stage.f
source/ex_pkg.sv
source/ex_alu.sv
source/ex_spr_bank.sv
source/ex_dotp_unit.sv
source/ex_writeback.sv
source/ex_stage.sv
dv/ex_stage_properties.sv
dv/ex_stage_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build ex_stage_tb with Verilator and run it"
	@echo "  clean  remove obj_dir"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module ex_stage_tb \
		-f ex_stage.f -o ex_stage_sim
	./obj_dir/ex_stage_sim

clean:
	rm -rf obj_dir
